// ==== csr_pkg.sv ====
/* Shared definitions for the performance-counter CSR block:
   widths, counter CSR addresses, operation and sequencer state enums */

package csr_pkg;

    // ============================================================
    // Widths
    // ============================================================

    // Register width, also the width of one counter half
    localparam int xlen = 32;

    // CSR address field of the instruction
    localparam int csr_addr_w = 12;

    // ============================================================
    // Counter CSR addresses
    // ============================================================

    // Low halves
    localparam logic [csr_addr_w-1:0] addr_mcycle    = 12'hB00;
    localparam logic [csr_addr_w-1:0] addr_minstret  = 12'hB02;

    // High halves, same offsets in the upper block
    localparam logic [csr_addr_w-1:0] addr_mcycleh   = 12'hB80;
    localparam logic [csr_addr_w-1:0] addr_minstreth = 12'hB82;

    // ============================================================
    // CSR operation
    // ============================================================

    // Taken straight from funct3[1:0]
    // Code 0 is not a CSR op here and falls into the default path
    typedef enum logic [1:0] {
        csr_rw = 2'd1,
        csr_rs = 2'd2,
        csr_rc = 2'd3
    } csr_op_e;

    // ============================================================
    // Access sequencer state
    // ============================================================

    // Idle until a start pulse, read once counters settle, write back
    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_write
    } csr_state_e;

endpackage

// ==== hpm_counter64.sv ====
/* 64-bit performance counter made of two 32-bit halves,
   registered carry between halves, per-half loads and a settled flag */

`timescale 1ns/1ps

module hpm_counter64 (
    input  logic                       clk,
    input  logic                       rstz,
    input  logic                       incr,
    input  logic [csr_pkg::xlen-1:0]   load_data,
    input  logic                       load_low,
    input  logic                       load_high,
    output logic [2*csr_pkg::xlen-1:0] count,
    output logic                       count_vld
);

    // ============================================================
    // Counter state
    // ============================================================

    // Lower and upper halves
    logic [csr_pkg::xlen-1:0] cnt_lo;
    logic [csr_pkg::xlen-1:0] cnt_hi;

    // Carry out of the low half, waiting for the high half
    logic carry_q;

    // Low half plus increment, one extra bit for the wrap
    logic [csr_pkg::xlen:0] lo_sum;

    // High half plus the pending carry
    logic [csr_pkg::xlen-1:0] hi_sum;

    // ============================================================
    // Increment paths
    // ============================================================

    // Only 33-bit and 32-bit adders, no 64-bit carry chain
    assign lo_sum = {1'b0, cnt_lo} + {{csr_pkg::xlen{1'b0}}, incr};

    // High half moves one clock after the low half wraps
    assign hi_sum = cnt_hi + {{(csr_pkg::xlen-1){1'b0}}, carry_q};

    // ============================================================
    // Low half and carry
    // ============================================================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            cnt_lo <= '0;
        end else if (load_low) begin
            // Load beats the increment
            cnt_lo <= load_data;
        end else begin
            cnt_lo <= lo_sum[csr_pkg::xlen-1:0];
        end
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            carry_q <= 1'b0;
        end else if (load_low) begin
            // New low value, so any wrap in flight is void
            carry_q <= 1'b0;
        end else begin
            // Set only for the one clock after a wrap
            carry_q <= lo_sum[csr_pkg::xlen];
        end
    end

    // ============================================================
    // High half
    // ============================================================

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            cnt_hi <= '0;
        end else if (load_high) begin
            // Load beats a pending carry
            cnt_hi <= load_data;
        end else begin
            cnt_hi <= hi_sum;
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    assign count = {cnt_hi, cnt_lo};

    // Halves disagree only while a carry is pending
    assign count_vld = ~carry_q;

endmodule

// ==== csr_access.sv ====
/* CSR access sequencer: decodes csrrw/csrrs/csrrc, reads a counter half,
   forms the modified value and steers half-writes to both counters */

`timescale 1ns/1ps

module csr_access (
    input  logic                       clk,
    input  logic                       rstz,
    // Instruction side
    input  logic [csr_pkg::xlen-1:0]   ir,
    input  logic [csr_pkg::xlen-1:0]   wr_data,
    input  logic                       csr_start,
    output logic [csr_pkg::xlen-1:0]   rd_data,
    output logic [4:0]                 csr_rd,
    output logic                       csr_write,
    output logic                       done,
    // Counter side
    input  logic [2*csr_pkg::xlen-1:0] cycle_count,
    input  logic                       cycle_vld,
    input  logic [2*csr_pkg::xlen-1:0] instret_count,
    input  logic                       instret_vld,
    output logic [csr_pkg::xlen-1:0]   load_data,
    output logic                       cycle_load_low,
    output logic                       cycle_load_high,
    output logic                       instret_load_low,
    output logic                       instret_load_high
);

    // ============================================================
    // Declarations
    // ============================================================

    csr_pkg::csr_state_e state;
    csr_pkg::csr_state_e next_state;

    // Decoded straight off the instruction
    csr_pkg::csr_op_e          ir_op;
    logic [4:0]                ir_rs1;
    logic [4:0]                ir_rd;
    logic                      ir_set_clr;

    // Latched at the accepted start
    csr_pkg::csr_op_e          op_q;
    logic [csr_pkg::csr_addr_w-1:0] addr_q;
    logic [csr_pkg::xlen-1:0]  wdata_q;
    logic                      wr_en_q;
    logic                      wb_en_q;

    // Sequencing strobes
    logic                      start_ok;
    logic                      both_vld;
    logic                      rd_en;
    logic                      wr_en;

    // Addressed counter half
    logic [csr_pkg::xlen-1:0]  rd_mux;

    // ============================================================
    // Instruction decode
    // ============================================================

    // funct3[1:0] selects rw/rs/rc, funct3[2] (immediate form) not used
    assign ir_op  = csr_pkg::csr_op_e'(ir[13:12]);
    assign ir_rs1 = ir[19:15];
    assign ir_rd  = ir[11:7];

    assign ir_set_clr = (ir_op == csr_pkg::csr_rs) || (ir_op == csr_pkg::csr_rc);

    // Start only counts while idle
    assign start_ok = (state == csr_pkg::st_idle) && csr_start;

    // ============================================================
    // Sequencer FSM
    // ============================================================

    // Both counters must show consistent halves before a read
    assign both_vld = cycle_vld && instret_vld;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= csr_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csr_pkg::st_idle: begin
                if (csr_start) begin
                    next_state = csr_pkg::st_read;
                end
            end
            csr_pkg::st_read: begin
                // At most one extra cycle for a pending carry
                if (both_vld) begin
                    next_state = csr_pkg::st_write;
                end
            end
            csr_pkg::st_write: begin
                next_state = csr_pkg::st_idle;
            end
            default: begin
                next_state = csr_pkg::st_idle;
            end
        endcase
    end

    // ============================================================
    // Latched instruction fields
    // ============================================================

    always_ff @(posedge clk) begin
        if (start_ok) begin
            op_q    <= ir_op;
            addr_q  <= ir[31:20];
            csr_rd  <= ir_rd;
            wdata_q <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            wr_en_q <= 1'b0;
            wb_en_q <= 1'b0;
        end else if (start_ok) begin
            // Set/clear with rs1 = x0 must not touch the CSR
            wr_en_q <= !(ir_set_clr && (ir_rs1 == 5'd0));
            // No writeback to x0
            wb_en_q <= (ir_rd != 5'd0);
        end
    end

    // ============================================================
    // CSR read
    // ============================================================

    // Unknown addresses read as zero
    always_comb begin
        rd_mux = '0;
        case (addr_q)
            csr_pkg::addr_mcycle:    rd_mux = cycle_count[csr_pkg::xlen-1:0];
            csr_pkg::addr_mcycleh:   rd_mux = cycle_count[2*csr_pkg::xlen-1:csr_pkg::xlen];
            csr_pkg::addr_minstret:  rd_mux = instret_count[csr_pkg::xlen-1:0];
            csr_pkg::addr_minstreth: rd_mux = instret_count[2*csr_pkg::xlen-1:csr_pkg::xlen];
            default:                 rd_mux = '0;
        endcase
    end

    assign rd_en = (state == csr_pkg::st_read) && both_vld;

    // Old value, held until the next access reads again
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

    // ============================================================
    // CSR write
    // ============================================================

    // Modify the captured old value
    always_comb begin
        case (op_q)
            csr_pkg::csr_rs: load_data = rd_data | wdata_q;
            csr_pkg::csr_rc: load_data = rd_data & ~wdata_q;
            default:         load_data = wdata_q;
        endcase
    end

    assign wr_en = (state == csr_pkg::st_write) && wr_en_q;

    // One strobe per counter half, unknown address hits none
    assign cycle_load_low    = wr_en && (addr_q == csr_pkg::addr_mcycle);
    assign cycle_load_high   = wr_en && (addr_q == csr_pkg::addr_mcycleh);
    assign instret_load_low  = wr_en && (addr_q == csr_pkg::addr_minstret);
    assign instret_load_high = wr_en && (addr_q == csr_pkg::addr_minstreth);

    // ============================================================
    // Completion
    // ============================================================

    assign done      = (state == csr_pkg::st_write);
    assign csr_write = (state == csr_pkg::st_write) && wb_en_q;

endmodule

// ==== csr_top.sv ====
/* Performance-counter CSR block: access sequencer with the
   mcycle and minstret counters */

`timescale 1ns/1ps

module csr_top (
    input  logic                     clk,
    input  logic                     rstz,
    input  logic [csr_pkg::xlen-1:0] ir,
    input  logic [csr_pkg::xlen-1:0] wr_data,
    input  logic                     csr_start,
    input  logic                     instret,
    output logic [csr_pkg::xlen-1:0] rd_data,
    output logic [4:0]               csr_rd,
    output logic                     csr_write,
    output logic                     done
);

    // ============================================================
    // Counter interconnect
    // ============================================================

    // Shared write value for all counter halves
    logic [csr_pkg::xlen-1:0]   load_data;

    // mcycle
    logic [2*csr_pkg::xlen-1:0] cycle_count;
    logic                       cycle_vld;
    logic                       cycle_load_low;
    logic                       cycle_load_high;

    // minstret
    logic [2*csr_pkg::xlen-1:0] instret_count;
    logic                       instret_vld;
    logic                       instret_load_low;
    logic                       instret_load_high;

    // ============================================================
    // Sequencer
    // ============================================================

    csr_access i_access (
        .clk               (clk),
        .rstz              (rstz),
        .ir                (ir),
        .wr_data           (wr_data),
        .csr_start         (csr_start),
        .rd_data           (rd_data),
        .csr_rd            (csr_rd),
        .csr_write         (csr_write),
        .done              (done),
        .cycle_count       (cycle_count),
        .cycle_vld         (cycle_vld),
        .instret_count     (instret_count),
        .instret_vld       (instret_vld),
        .load_data         (load_data),
        .cycle_load_low    (cycle_load_low),
        .cycle_load_high   (cycle_load_high),
        .instret_load_low  (instret_load_low),
        .instret_load_high (instret_load_high)
    );

    // ============================================================
    // Counters
    // ============================================================

    // Cycle counter, runs every clock
    hpm_counter64 i_mcycle (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (1'b1),
        .load_data (load_data),
        .load_low  (cycle_load_low),
        .load_high (cycle_load_high),
        .count     (cycle_count),
        .count_vld (cycle_vld)
    );

    // Retired-instruction counter
    hpm_counter64 i_minstret (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (instret),
        .load_data (load_data),
        .load_low  (instret_load_low),
        .load_high (instret_load_high),
        .count     (instret_count),
        .count_vld (instret_vld)
    );

endmodule

// ==== tb_csr_top.sv ====
/* Testbench for csr_top: clock, reset, CSR instruction driver, minstret model,
   assertions on the access timing, watchdog and final report */

`timescale 1ns/1ps

module tb_csr_top;

    localparam int clk_period = 20;
    // Twice the length of 60 four-cycle accesses and 160 instret cycles
    localparam int timeout_ns = (60 * 4 + 160) * clk_period * 2;

    logic        clk;
    logic        rstz;
    logic [31:0] ir;
    logic [31:0] wr_data;
    logic        csr_start;
    logic        instret;
    logic [31:0] rd_data;
    logic [4:0]  csr_rd;
    logic        csr_write;
    logic        done;

    int          errors;
    logic [31:0] lcg_state;
    // Reference minstret value
    logic [63:0] model;

    csr_top i_dut (
        .clk       (clk),
        .rstz      (rstz),
        .ir        (ir),
        .wr_data   (wr_data),
        .csr_start (csr_start),
        .instret   (instret),
        .rd_data   (rd_data),
        .csr_rd    (csr_rd),
        .csr_write (csr_write),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ============================================================
    // Timing assertions
    // ============================================================

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rstz) done |=> !done)
        else begin
            errors++;
            $display("Fail done: got %h expected %h one cycle after done", 1'b1, 1'b0);
        end

    // Writeback request only in the done cycle
    a_write_in_done: assert property (@(posedge clk) disable iff (!rstz) csr_write |-> done)
        else begin
            errors++;
            $display("Fail done: got %h expected %h while csr_write high",
                     $sampled(done), 1'b1);
        end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // New CSR value from the old one and the rs1 operand
    function automatic logic [31:0] apply_op(input csr_pkg::csr_op_e op,
                                             input logic [31:0] old, input logic [31:0] src);
        case (op)
            csr_pkg::csr_rw: return src;
            csr_pkg::csr_rs: return old | src;
            csr_pkg::csr_rc: return old & ~src;
            default:         return old;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Issue one CSR instruction and return the old value at done
    task automatic run_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [4:0] rs1, input logic [4:0] rd,
                           input logic [31:0] src, output logic [31:0] old);
        int lat;
        csr_pkg::csr_state_e want;
        want = csr_pkg::st_write;
        @(posedge clk);
        ir        <= {addr, rs1, 1'b0, op, rd, 7'b1110011};
        wr_data   <= src;
        csr_start <= 1'b1;
        @(posedge clk);
        csr_start <= 1'b0;
        lat = 1;
        @(negedge clk);
        // Bounded wait for done
        while (!done && lat < 4) begin
            @(negedge clk);
            lat++;
        end
        assert (done) else begin
            errors++;
            $display("No done %0d cycles after csr_start, sequencer never reached %s",
                     lat, want.name());
        end
        assert (lat >= 2 && lat <= 3) else begin
            errors++;
            $display("Fail done latency: got %h expected 2 or 3 cycles", lat);
        end
        old = rd_data;
        check_value("csr_rd", {27'd0, csr_rd}, {27'd0, rd});
        check_value("csr_write", {31'd0, csr_write}, {31'd0, rd != 5'd0});
        // Write pulse lands on this edge
        @(posedge clk);
    endtask

    // Access one minstret half and keep the model in step
    task automatic minstret_access(input csr_pkg::csr_op_e op, input logic hi,
                                   input logic [4:0] rs1, input logic [4:0] rd,
                                   input logic [31:0] src);
        logic [31:0] exp_old;
        logic [31:0] got;
        string name;
        exp_old = hi ? model[63:32] : model[31:0];
        name = hi ? "minstreth" : "minstret";
        run_csr(op, hi ? csr_pkg::addr_minstreth : csr_pkg::addr_minstret, rs1, rd, src, got);
        check_value(name, got, exp_old);
        // Set and clear with rs1 = x0 leave the CSR alone
        if (op == csr_pkg::csr_rw || rs1 != 5'd0) begin
            if (hi) begin
                model[63:32] = apply_op(op, exp_old, src);
            end else begin
                model[31:0] = apply_op(op, exp_old, src);
            end
        end
    endtask

    // n consecutive instret samples and time for the carry to settle
    task automatic pulse_instret(input int n);
        repeat (n) begin
            @(posedge clk);
            instret <= 1'b1;
        end
        @(posedge clk);
        instret <= 1'b0;
        repeat (2) @(posedge clk);
        model = model + 64'(n);
    endtask

    // ============================================================
    // Watchdog
    // ============================================================

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, run did not complete", timeout_ns);
        $display("TEST FAILED");
        $finish;
    end

    // ============================================================
    // Test sequence
    // ============================================================

    initial begin
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] got;
        int          k;
        rstz      = 1'b0;
        ir        = '0;
        wr_data   = '0;
        csr_start = 1'b0;
        instret   = 1'b0;
        errors    = 0;
        model     = '0;
        lcg_state = 32'h6ab5_5c50;
        repeat (2) @(posedge clk);
        rstz <= 1'b1;
        @(negedge clk);
        check_value("done", {31'd0, done}, 32'd0);
        check_value("csr_write", {31'd0, csr_write}, 32'd0);

        // Plain writes to both halves and read back
        minstret_access(csr_pkg::csr_rw, 1'b0, 5'd1, 5'd10, lcg_next());
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd11, 32'd0);
        minstret_access(csr_pkg::csr_rw, 1'b1, 5'd2, 5'd10, lcg_next());
        minstret_access(csr_pkg::csr_rs, 1'b1, 5'd0, 5'd11, 32'd0);

        // Set and clear with random masks
        for (int i = 0; i < 4; i++) begin
            minstret_access(csr_pkg::csr_rs, 1'b0, 5'd3, 5'd12, lcg_next());
            minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd12, 32'd0);
            minstret_access(csr_pkg::csr_rc, 1'b0, 5'd4, 5'd13, lcg_next());
            minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd13, 32'd0);
        end
        // rs1 = x0 with a full mask on wr_data changes nothing
        minstret_access(csr_pkg::csr_rc, 1'b0, 5'd0, 5'd14, 32'hffff_ffff);
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd14, 32'd0);
        // No writeback request for rd = x0
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd6, 5'd0, lcg_next());

        // Exact counting of random pulse bursts
        for (int i = 0; i < 4; i++) begin
            pulse_instret(1 + int'(lcg_next() % 32'd16));
            minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd15, 32'd0);
        end

        // High half picks up the carry of a low wrap
        minstret_access(csr_pkg::csr_rw, 1'b0, 5'd7, 5'd16, 32'hffff_ffff);
        pulse_instret(1);
        minstret_access(csr_pkg::csr_rs, 1'b1, 5'd0, 5'd17, 32'd0);
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd18, 32'd0);

        // Wrap on the edge that samples csr_start
        // The read has to wait out the pending carry
        minstret_access(csr_pkg::csr_rw, 1'b0, 5'd7, 5'd16, 32'hffff_ffff);
        fork
            begin
                @(posedge clk);
                instret <= 1'b1;
                @(posedge clk);
                instret <= 1'b0;
            end
        join_none
        model = model + 64'd1;
        minstret_access(csr_pkg::csr_rs, 1'b1, 5'd0, 5'd17, 32'd0);
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd18, 32'd0);

        // mcycle advances with the idle gap
        run_csr(csr_pkg::csr_rs, csr_pkg::addr_mcycle, 5'd0, 5'd20, 32'd0, t0);
        k = 5 + int'(lcg_next() % 32'd16);
        repeat (k) @(posedge clk);
        run_csr(csr_pkg::csr_rs, csr_pkg::addr_mcycle, 5'd0, 5'd21, 32'd0, t1);
        assert ((t1 - t0) >= 32'(k) && (t1 - t0) <= 32'(k + 6)) else begin
            errors++;
            $display("Fail mcycle delta: got %h expected %h to %h", t1 - t0, k, k + 6);
        end

        // Unknown addresses read zero and drop writes
        run_csr(csr_pkg::csr_rs, 12'h340, 5'd0, 5'd22, 32'd0, got);
        check_value("rd_data", got, 32'd0);
        run_csr(csr_pkg::csr_rw, 12'h7c0, 5'd8, 5'd23, lcg_next(), got);
        check_value("rd_data", got, 32'd0);
        minstret_access(csr_pkg::csr_rs, 1'b0, 5'd0, 5'd24, 32'd0);

        @(posedge clk);
        $display("Run complete, errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
csr_pkg.sv
hpm_counter64.sv
csr_access.sv
csr_top.sv
tb_csr_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the csr_top testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_csr_top -f all.f -o sim_csr \
    && ./obj_dir/sim_csr > sim.log 2>&1 \
    || echo "Build or simulation aborted" >> sim.log

cat sim.log

# A failure line in the log decides the result
grep -q "TEST FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }

# A run that never reached its report also fails
grep -q "TEST PASSED" sim.log || { echo "No pass report in sim.log"; exit 1; }

echo "Simulation finished cleanly"
exit 0
